// ==== verilog/robocup_pkg.sv ====
`default_nettype none

package robocup_pkg;

	// Motor speed width, also the width of the shared PWM carrier
	localparam int SPEED_W = 9;
	// Quadrature count width
	localparam int ENC_W = 16;
	localparam int NUM_MOTORS = 5;
	localparam int NUM_ENCODERS = 4;
	// Two bytes per motor in a full command packet
	localparam int CMD_BYTES = 10;

	// Hall sensor sample, ordered {a, b, c}
	typedef struct packed {
		logic a;
		logic b;
		logic c;
	} hall_t;

	// One half-bridge, high side switch above low side switch
	typedef struct packed {
		logic high;
		logic low;
	} half_bridge_t;

	// Six gate signals, {a_h, a_l, b_h, b_l, c_h, c_l}
	typedef struct packed {
		half_bridge_t a;
		half_bridge_t b;
		half_bridge_t c;
	} motor_out_t;

	// Speed and direction for one motor
	typedef struct packed {
		logic dir;
		logic [SPEED_W-1:0] speed;
	} motor_cmd_t;

	// Encoder channel pair
	typedef struct packed {
		logic a;
		logic b;
	} quad_t;

	// Commutation sector, named high phase then low phase
	typedef enum logic [2:0] {
		sector_ab,
		sector_ac,
		sector_bc,
		sector_ba,
		sector_ca,
		sector_cb,
		sector_invalid
	} sector_e;

endpackage

`default_nettype wire

// ==== verilog/spi_slave.sv ====
`timescale 1ns/10ps
`default_nettype none

module spi_slave #(
	parameter logic [7:0] SPI_VERSION = 8'h02
) (
	input logic sysclk,
	input logic reset,
	input logic sck,
	input logic mosi,
	input logic fpga_ncs,
	input logic [robocup_pkg::ENC_W-1:0] enc_count [robocup_pkg::NUM_ENCODERS],
	input logic [robocup_pkg::NUM_MOTORS-1:0] fault,
	inout wire miso,
	output robocup_pkg::motor_cmd_t motor_cmd [robocup_pkg::NUM_MOTORS]
);

	// Two-stage synchronizers for the SPI pins
	logic sck_meta;
	logic sck_sync;
	logic sck_prev;
	logic mosi_meta;
	logic mosi_sync;
	logic ncs_meta;
	logic ncs_sync;

	// Shift register, MISO is its top bit
	logic [7:0] shift_reg;
	// MOSI bit held from rising edge until the falling edge shift
	logic mosi_bit;
	logic [2:0] bit_count;
	// Index of the current byte in the packet, saturates at 15
	logic [3:0] byte_count;
	// One cycle pulse after the last bit of a byte is sampled
	logic byte_strobe;

	logic [7:0] rx_byte [robocup_pkg::CMD_BYTES];
	logic [robocup_pkg::ENC_W-1:0] enc_capture [robocup_pkg::NUM_ENCODERS];

	logic sck_rise;
	logic sck_fall;

	always_ff @(posedge sysclk) begin
		sck_meta <= sck;
		sck_sync <= sck_meta;
		sck_prev <= sck_sync;
		mosi_meta <= mosi;
		mosi_sync <= mosi_meta;
		ncs_meta <= fpga_ncs;
		ncs_sync <= ncs_meta;
	end

	assign sck_rise = sck_sync & ~sck_prev;
	assign sck_fall = ~sck_sync & sck_prev;

	always_ff @(posedge sysclk) begin
		if (reset) begin
			shift_reg <= SPI_VERSION;
			mosi_bit <= 1'b0;
			bit_count <= '0;
			byte_count <= '0;
			byte_strobe <= 1'b0;
		end else begin
			byte_strobe <= 1'b0;
			if (ncs_sync) begin
				// Idle between packets, first byte out is the version
				shift_reg <= SPI_VERSION;
				bit_count <= '0;
				byte_count <= '0;
			end else begin
				// Mode 0 sample point
				if (sck_rise) begin
					mosi_bit <= mosi_sync;
					if (bit_count == 3'd7)
						byte_strobe <= 1'b1;
				end
				if (sck_fall) begin
					bit_count <= bit_count + 3'd1;
					if (bit_count == 3'd7) begin
						// Byte done, load the status byte for the next slot
						if (byte_count < 4'd8)
							shift_reg <= byte_count[0] ?
								enc_capture[byte_count[2:1]][15:8] :
								enc_capture[byte_count[2:1]][7:0];
						else if (byte_count == 4'd8)
							shift_reg <= {3'b000, fault};
						else
							shift_reg <= 8'h00;
						if (byte_count != 4'hf)
							byte_count <= byte_count + 4'd1;
					end else begin
						shift_reg <= {shift_reg[6:0], mosi_bit};
					end
				end
			end
		end
	end

	// Received byte store, extra bytes of a long packet are dropped
	always_ff @(posedge sysclk) begin
		if (!ncs_sync && sck_rise && bit_count == 3'd7 &&
				byte_count < 4'(robocup_pkg::CMD_BYTES))
			rx_byte[byte_count] <= {shift_reg[6:0], mosi_sync};
	end

	// Snapshot every encoder at the end of the first byte
	always_ff @(posedge sysclk) begin
		if (reset) begin
			for (int i = 0; i < robocup_pkg::NUM_ENCODERS; i++)
				enc_capture[i] <= '0;
		end else if (byte_strobe && byte_count == 4'd0) begin
			for (int i = 0; i < robocup_pkg::NUM_ENCODERS; i++)
				enc_capture[i] <= enc_count[i];
		end
	end

	// Commands only take effect after an exact-length packet
	always_ff @(posedge sysclk) begin
		if (reset) begin
			for (int k = 0; k < robocup_pkg::NUM_MOTORS; k++)
				motor_cmd[k] <= '0;
		end else if (ncs_sync && byte_count == 4'(robocup_pkg::CMD_BYTES)) begin
			for (int k = 0; k < robocup_pkg::NUM_MOTORS; k++) begin
				motor_cmd[k].speed <= {rx_byte[2*k+1][0], rx_byte[2*k]};
				motor_cmd[k].dir <= rx_byte[2*k+1][1];
			end
		end
	end

	// Released while the chip is not selected
	assign miso = fpga_ncs ? 1'bz : shift_reg[7];

endmodule

`default_nettype wire

// ==== verilog/pwm_phase_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module pwm_phase_gen #(
	parameter logic [robocup_pkg::SPEED_W-1:0] PWM_PEAK = 9'h1fd
) (
	input logic sysclk,
	input logic reset,
	output logic [robocup_pkg::SPEED_W-1:0] pwm_phase
);

	// High while the triangle ramps down
	logic count_down;

	always_ff @(posedge sysclk) begin
		if (reset) begin
			pwm_phase <= '0;
			count_down <= 1'b0;
		end else if (!count_down) begin
			// Turn around one step past the peak
			if (pwm_phase == PWM_PEAK)
				count_down <= 1'b1;
			pwm_phase <= pwm_phase + 1'b1;
		end else begin
			if (pwm_phase == 1)
				count_down <= 1'b0;
			pwm_phase <= pwm_phase - 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/bldc_driver.sv ====
`timescale 1ns/10ps
`default_nettype none

module bldc_driver (
	input logic sysclk,
	input logic reset,
	input logic [robocup_pkg::SPEED_W-1:0] pwm_phase,
	input robocup_pkg::motor_cmd_t cmd,
	input robocup_pkg::hall_t hall,
	output robocup_pkg::motor_out_t drive,
	output logic fault
);

	robocup_pkg::hall_t hall_meta;
	robocup_pkg::hall_t hall_sync;
	robocup_pkg::sector_e sector;
	// One-hot phase selects, bit 2 is phase A
	logic [2:0] fwd_high;
	logic [2:0] fwd_low;
	logic [2:0] high_sel;
	logic [2:0] low_sel;
	logic pwm_on;
	robocup_pkg::motor_out_t drive_next;

	// Hall lines are asynchronous to sysclk
	always_ff @(posedge sysclk) begin
		hall_meta <= hall;
		hall_sync <= hall_meta;
	end

	always_comb begin
		case (hall_sync)
			3'b101: sector = robocup_pkg::sector_ab;
			3'b100: sector = robocup_pkg::sector_ac;
			3'b110: sector = robocup_pkg::sector_bc;
			3'b010: sector = robocup_pkg::sector_ba;
			3'b011: sector = robocup_pkg::sector_ca;
			3'b001: sector = robocup_pkg::sector_cb;
			// 000 and 111 mean a broken sensor or cable
			default: sector = robocup_pkg::sector_invalid;
		endcase
	end

	always_comb begin
		case (sector)
			robocup_pkg::sector_ab: {fwd_high, fwd_low} = {3'b100, 3'b010};
			robocup_pkg::sector_ac: {fwd_high, fwd_low} = {3'b100, 3'b001};
			robocup_pkg::sector_bc: {fwd_high, fwd_low} = {3'b010, 3'b001};
			robocup_pkg::sector_ba: {fwd_high, fwd_low} = {3'b010, 3'b100};
			robocup_pkg::sector_ca: {fwd_high, fwd_low} = {3'b001, 3'b100};
			robocup_pkg::sector_cb: {fwd_high, fwd_low} = {3'b001, 3'b010};
			default: {fwd_high, fwd_low} = {3'b000, 3'b000};
		endcase
	end

	// Reverse just swaps the driven pair
	assign high_sel = cmd.dir ? fwd_low : fwd_high;
	assign low_sel = cmd.dir ? fwd_high : fwd_low;

	// Chop only the high side, low side stays on for the sector
	assign pwm_on = pwm_phase < cmd.speed;

	always_comb begin
		drive_next.a.high = high_sel[2] & pwm_on;
		drive_next.a.low = low_sel[2];
		drive_next.b.high = high_sel[1] & pwm_on;
		drive_next.b.low = low_sel[1];
		drive_next.c.high = high_sel[0] & pwm_on;
		drive_next.c.low = low_sel[0];
	end

	always_ff @(posedge sysclk) begin
		if (reset) begin
			drive <= '0;
			fault <= 1'b0;
		end else begin
			drive <= drive_next;
			fault <= (sector == robocup_pkg::sector_invalid);
		end
	end

endmodule

`default_nettype wire

// ==== verilog/quad_encoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module quad_encoder (
	input logic sysclk,
	input logic reset,
	input robocup_pkg::quad_t enc,
	output logic [robocup_pkg::ENC_W-1:0] count
);

	robocup_pkg::quad_t enc_meta;
	robocup_pkg::quad_t enc_sync;
	robocup_pkg::quad_t enc_prev;
	// Neighbours of the previous state in 00 -> 01 -> 11 -> 10
	robocup_pkg::quad_t fwd_next;
	robocup_pkg::quad_t rev_next;

	always_ff @(posedge sysclk) begin
		enc_meta <= enc;
		enc_sync <= enc_meta;
		enc_prev <= enc_sync;
	end

	always_comb begin
		case (enc_prev)
			2'b00: {fwd_next, rev_next} = {2'b01, 2'b10};
			2'b01: {fwd_next, rev_next} = {2'b11, 2'b00};
			2'b11: {fwd_next, rev_next} = {2'b10, 2'b01};
			default: {fwd_next, rev_next} = {2'b00, 2'b11};
		endcase
	end

	// Both bits changing is a lost step, so the count holds
	always_ff @(posedge sysclk) begin
		if (reset)
			count <= '0;
		else if (enc_sync == fwd_next)
			count <= count + 1'b1;
		else if (enc_sync == rev_next)
			count <= count - 1'b1;
	end

endmodule

`default_nettype wire

// ==== verilog/robocup.sv ====
`timescale 1ns/10ps
`default_nettype none

module robocup #(
	parameter logic [7:0] SPI_VERSION = 8'h02,
	parameter logic [robocup_pkg::SPEED_W-1:0] PWM_PEAK = 9'h1fd
) (
	input logic sysclk,
	input logic reset,
	input robocup_pkg::hall_t hall [robocup_pkg::NUM_MOTORS],
	input robocup_pkg::quad_t enc [robocup_pkg::NUM_ENCODERS],
	input logic fpga_ncs,
	input logic mosi,
	input logic sck,
	output robocup_pkg::motor_out_t bridge [robocup_pkg::NUM_MOTORS],
	inout wire miso
);

	// Shared triangle carrier
	logic [robocup_pkg::SPEED_W-1:0] pwm_phase;
	robocup_pkg::motor_cmd_t motor_cmd [robocup_pkg::NUM_MOTORS];
	// Bit 0 is motor 1
	logic [robocup_pkg::NUM_MOTORS-1:0] motor_fault;
	logic [robocup_pkg::ENC_W-1:0] enc_count [robocup_pkg::NUM_ENCODERS];

	spi_slave #(
		.SPI_VERSION(SPI_VERSION)
	) spi_slave_inst (
		.sysclk(sysclk),
		.reset(reset),
		.sck(sck),
		.mosi(mosi),
		.fpga_ncs(fpga_ncs),
		.enc_count(enc_count),
		.fault(motor_fault),
		.miso(miso),
		.motor_cmd(motor_cmd)
	);

	pwm_phase_gen #(
		.PWM_PEAK(PWM_PEAK)
	) pwm_phase_gen_inst (
		.sysclk(sysclk),
		.reset(reset),
		.pwm_phase(pwm_phase)
	);

	for (genvar k = 0; k < robocup_pkg::NUM_MOTORS; k++) begin : gen_motor
		bldc_driver bldc_driver_inst (
			.sysclk(sysclk),
			.reset(reset),
			.pwm_phase(pwm_phase),
			.cmd(motor_cmd[k]),
			.hall(hall[k]),
			.drive(bridge[k]),
			.fault(motor_fault[k])
		);
	end

	// Motor 5 has no encoder
	for (genvar i = 0; i < robocup_pkg::NUM_ENCODERS; i++) begin : gen_encoder
		quad_encoder quad_encoder_inst (
			.sysclk(sysclk),
			.reset(reset),
			.enc(enc[i]),
			.count(enc_count[i])
		);
	end

endmodule

`default_nettype wire

// ==== sim/robocup_assert.sv ====
`timescale 1ns/10ps
`default_nettype none

module robocup_assert (
	input logic sysclk,
	input logic reset,
	input robocup_pkg::motor_out_t bridge [robocup_pkg::NUM_MOTORS],
	input logic [robocup_pkg::NUM_MOTORS-1:0] motor_fault
);

	// Running total of failed assertions, polled by the testbench
	int unsigned fail_count = 0;

	for (genvar k = 0; k < robocup_pkg::NUM_MOTORS; k++) begin : gen_motor_check
		// Gate signals regrouped by side, bit 2 is phase A
		logic [2:0] highs;
		logic [2:0] lows;

		assign highs = {bridge[k].a.high, bridge[k].b.high, bridge[k].c.high};
		assign lows = {bridge[k].a.low, bridge[k].b.low, bridge[k].c.low};

		// Shoot-through on any leg
		no_shoot_through: assert property (@(posedge sysclk) disable iff (reset)
			(highs & lows) == 3'b000)
			else begin
				$error("Motor %0d drives both switches of one phase", k + 1);
				fail_count++;
			end

		// Gates and fault released during reset
		reset_quiet: assert property (@(posedge sysclk)
			reset |=> (bridge[k] == '0 && !motor_fault[k]))
			else begin
				$error("Motor %0d is not quiet during reset", k + 1);
				fail_count++;
			end

		// Fault comes from the same sector sample as the outputs
		invalid_sector_off: assert property (@(posedge sysclk) disable iff (reset)
			motor_fault[k] |-> bridge[k] == '0)
			else begin
				$error("Motor %0d drives a switch with an invalid Hall sector", k + 1);
				fail_count++;
			end

		// One driven pair per sector
		one_pair: assert property (@(posedge sysclk) disable iff (reset)
			$onehot0(highs) && $onehot0(lows))
			else begin
				$error("Motor %0d has more than one high or low switch on", k + 1);
				fail_count++;
			end
	end

endmodule

`default_nettype wire

// ==== sim/robocup_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module robocup_tb;

	localparam logic [7:0] VERSION = 8'h02;
	localparam logic [robocup_pkg::SPEED_W-1:0] PEAK = 9'h1fd;
	// SCK half-period in sysclk cycles
	localparam int HALF_SCK = 5;
	// One full up/down carrier period plus margin
	localparam int PWM_SPAN = 2 * (PEAK + 2) + 8;

	logic sysclk = 1'b0;
	logic reset;
	robocup_pkg::hall_t hall [robocup_pkg::NUM_MOTORS];
	robocup_pkg::quad_t enc [robocup_pkg::NUM_ENCODERS];
	logic fpga_ncs;
	logic mosi;
	logic sck;
	robocup_pkg::motor_out_t bridge [robocup_pkg::NUM_MOTORS];
	wire miso;

	logic [31:0] lfsr = 32'h267e;
	logic [7:0] tx_buf [10];
	logic [7:0] rx_buf [10];
	// Expected encoder counts, tracked from the steps issued
	logic [15:0] enc_model [robocup_pkg::NUM_ENCODERS];
	// Valid Hall codes in forward rotation order
	logic [2:0] valid_codes [6] = '{3'b101, 3'b100, 3'b110, 3'b010, 3'b011, 3'b001};

	robocup #(
		.SPI_VERSION(VERSION),
		.PWM_PEAK(PEAK)
	) robocup_inst (
		.sysclk(sysclk),
		.reset(reset),
		.hall(hall),
		.enc(enc),
		.fpga_ncs(fpga_ncs),
		.mosi(mosi),
		.sck(sck),
		.bridge(bridge),
		.miso(miso)
	);

	bind robocup robocup_assert robocup_assert_inst (
		.sysclk(sysclk),
		.reset(reset),
		.bridge(bridge),
		.motor_fault(motor_fault)
	);

	always #10 sysclk = ~sysclk;

	task automatic stop_failed();
		$display("SOME TESTS FAILED");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [15:0] got,
			input logic [15:0] exp);
		assert (got === exp) else begin
			$display("MISMATCH at %0t ns: %s = %h, expected %h", $time, name, got, exp);
			stop_failed();
		end
	endtask

	task automatic cycles(input int n);
		repeat (n) @(negedge sysclk);
	endtask

	// Fibonacci LFSR, taps 32 22 2 1, one step per bit
	task automatic take_bits(input int n, output logic [31:0] value);
		logic fb;
		value = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			value = {value[30:0], fb};
		end
	endtask

	// Mode 0 master, MSB first, miso taken just before each rising SCK
	task automatic spi_packet(input int n);
		fpga_ncs = 1'b0;
		cycles(HALF_SCK);
		for (int b = 0; b < n; b++) begin
			for (int i = 7; i >= 0; i--) begin
				mosi = tx_buf[b][i];
				cycles(HALF_SCK);
				rx_buf[b][i] = miso;
				sck = 1'b1;
				cycles(HALF_SCK);
				sck = 1'b0;
			end
		end
		cycles(HALF_SCK);
		fpga_ncs = 1'b1;
		// Covers the command latency after chip select rises
		cycles(8);
	endtask

	task automatic fill_commands(input logic [8:0] speed, input logic dir);
		for (int k = 0; k < robocup_pkg::NUM_MOTORS; k++) begin
			tx_buf[2*k] = speed[7:0];
			tx_buf[2*k+1] = {6'b000000, dir, speed[8]};
		end
	endtask

	// Gate pattern from the commutation table
	function automatic robocup_pkg::motor_out_t expected_drive(input logic [2:0] code,
			input logic dir, input logic high_on);
		logic [2:0] hi;
		logic [2:0] lo;
		logic [2:0] tmp;
		case (code)
			3'b101: {hi, lo} = {3'b100, 3'b010};
			3'b100: {hi, lo} = {3'b100, 3'b001};
			3'b110: {hi, lo} = {3'b010, 3'b001};
			3'b010: {hi, lo} = {3'b010, 3'b100};
			3'b011: {hi, lo} = {3'b001, 3'b100};
			3'b001: {hi, lo} = {3'b001, 3'b010};
			default: {hi, lo} = 6'b000000;
		endcase
		if (dir) begin
			tmp = hi;
			hi = lo;
			lo = tmp;
		end
		hi = hi & {3{high_on}};
		return {hi[2], lo[2], hi[1], lo[1], hi[0], lo[0]};
	endfunction

	// Gray sequence 00 -> 01 -> 11 -> 10 counts up
	task automatic move_encoder(input int i, input int steps, input logic reverse);
		for (int s = 0; s < steps; s++) begin
			enc[i] = reverse ? {~enc[i].b, enc[i].a} : {enc[i].b, ~enc[i].a};
			enc_model[i] = reverse ? enc_model[i] - 16'd1 : enc_model[i] + 16'd1;
			cycles(4);
		end
	endtask

	task automatic jump_encoder(input int i);
		enc[i] = {~enc[i].a, ~enc[i].b};
		cycles(4);
	endtask

	task automatic check_status(input logic [7:0] fault_byte);
		check_value("miso byte 0", rx_buf[0], VERSION);
		for (int i = 0; i < robocup_pkg::NUM_ENCODERS; i++) begin
			check_value($sformatf("capture %0d low", i + 1), rx_buf[2*i+1], enc_model[i][7:0]);
			check_value($sformatf("capture %0d high", i + 1), rx_buf[2*i+2], enc_model[i][15:8]);
		end
		check_value("fault byte", rx_buf[9], fault_byte);
	endtask

	task automatic check_commutation(input logic dir);
		for (int c = 0; c < 6; c++) begin
			for (int k = 0; k < robocup_pkg::NUM_MOTORS; k++)
				hall[k] = valid_codes[c];
			cycles(8);
			for (int k = 0; k < robocup_pkg::NUM_MOTORS; k++)
				check_value($sformatf("bridge[%0d]", k), bridge[k],
					expected_drive(valid_codes[c], dir, 1'b1));
		end
	endtask

	// Speed 0 forward with Hall 101, so only the B low switch may be on
	task automatic check_high_off(input int span);
		for (int t = 0; t < span; t++) begin
			@(negedge sysclk);
			for (int k = 0; k < robocup_pkg::NUM_MOTORS; k++)
				check_value($sformatf("bridge[%0d]", k), bridge[k],
					expected_drive(3'b101, 1'b0, 1'b0));
		end
	endtask

	always @(negedge sysclk) begin
		if (robocup_inst.robocup_assert_inst.fail_count != 0) begin
			$display("A bridge assertion failed at %0t ns", $time);
			stop_failed();
		end
	end

	initial begin
		#1_000_000;
		$display("Simulation did not finish within 1 ms");
		stop_failed();
	end

	initial begin
		logic [31:0] r;
		reset = 1'b1;
		sck = 1'b0;
		mosi = 1'b0;
		fpga_ncs = 1'b1;
		for (int k = 0; k < robocup_pkg::NUM_MOTORS; k++)
			hall[k] = 3'b101;
		for (int i = 0; i < robocup_pkg::NUM_ENCODERS; i++) begin
			enc[i] = 2'b00;
			enc_model[i] = '0;
		end
		cycles(16);
		for (int k = 0; k < robocup_pkg::NUM_MOTORS; k++)
			check_value($sformatf("bridge[%0d]", k), bridge[k], 16'h0000);
		assert (miso === 1'bz) else begin
			$display("miso is driven while fpga_ncs is high");
			stop_failed();
		end
		reset = 1'b0;
		cycles(4);

		// Version byte and zero captures, full speed forward
		fill_commands(9'h1ff, 1'b0);
		spi_packet(10);
		check_status(8'h00);

		// Random walks on each encoder with lost steps mixed in
		for (int i = 0; i < robocup_pkg::NUM_ENCODERS; i++) begin
			take_bits(6, r);
			move_encoder(i, r, 1'b0);
			take_bits(1, r);
			if (r[0])
				jump_encoder(i);
			take_bits(7, r);
			move_encoder(i, r, 1'b1);
			jump_encoder(i);
			take_bits(4, r);
			move_encoder(i, r, 1'b0);
		end

		// Broken Hall sensors on motors 2 and 5
		hall[1] = 3'b111;
		hall[4] = 3'b000;
		cycles(8);
		check_value("bridge[1]", bridge[1], 16'h0000);
		check_value("bridge[4]", bridge[4], 16'h0000);
		spi_packet(10);
		check_status(8'h12);

		check_commutation(1'b0);
		fill_commands(9'h1ff, 1'b1);
		spi_packet(10);
		check_commutation(1'b1);

		// Zero duty, then a short packet that must be ignored
		fill_commands(9'h000, 1'b0);
		spi_packet(10);
		for (int k = 0; k < robocup_pkg::NUM_MOTORS; k++)
			hall[k] = 3'b101;
		cycles(8);
		check_high_off(PWM_SPAN);
		for (int b = 0; b < 9; b++) begin
			take_bits(8, r);
			tx_buf[b] = r[7:0];
		end
		tx_buf[0][7] = 1'b1;
		spi_packet(9);
		check_high_off(PWM_SPAN);

		if (robocup_inst.robocup_assert_inst.fail_count == 0) begin
			$display("ALL TESTS PASSED");
			$finish;
		end else begin
			stop_failed();
		end
	end

endmodule

`default_nettype wire

// ==== robocup.f ====
verilog/robocup_pkg.sv
verilog/spi_slave.sv
verilog/pwm_phase_gen.sv
verilog/bldc_driver.sv
verilog/quad_encoder.sv
verilog/robocup.sv
sim/robocup_assert.sv
sim/robocup_tb.sv
